//--- hw/arch_regfile.sv
`timescale 1ns/1ps

module arch_regfile import rename_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  areg_id_t [SRC_N-1:0]          raddr_i,
    output logic [SRC_N-1:0][XLEN-1:0]    rdata_o,
    input  areg_id_t [ISSUE_N-1:0]        waddr_i,
    input  logic [ISSUE_N-1:0]            we_i,
    input  logic [ISSUE_N-1:0][XLEN-1:0]  wdata_i
);

    logic [AREG_N-1:0][XLEN-1:0] regs_q;

    // flush leaves committed values alone
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            regs_q <= '0;
        end else begin
            for (int k = 0; k < ISSUE_N; k++) begin
                if (we_i[k] && (waddr_i[k] != '0)) begin
                    regs_q[waddr_i[k]] <= wdata_i[k];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < SRC_N; r++) begin
            rdata_o[r] = regs_q[raddr_i[r]];
            for (int k = 0; k < ISSUE_N; k++) begin
                if (we_i[k] && (waddr_i[k] == raddr_i[r])) begin
                    rdata_o[r] = wdata_i[k];
                end
            end
            // r0 hardwired
            if (raddr_i[r] == '0) begin
                rdata_o[r] = '0;
            end
        end
    end

endmodule

//--- hw/commit_rat.sv
`timescale 1ns/1ps

module commit_rat import rename_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           flush_i,
    input  areg_id_t [SRC_N+ISSUE_N-1:0]   raddr_i,
    output rat_entry_t [SRC_N+ISSUE_N-1:0] rdata_o,
    input  areg_id_t [ISSUE_N-1:0]         waddr_i,
    input  logic [ISSUE_N-1:0]             we_i,
    input  rat_entry_t [ISSUE_N-1:0]       wdata_i
);

    rat_entry_t [AREG_N-1:0] map_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            map_q <= '0;
        end else begin
            for (int k = 0; k < ISSUE_N; k++) begin
                if (we_i[k]) begin
                    map_q[waddr_i[k]] <= wdata_i[k];
                end
            end
        end
    end

    // retire writes bypass into same-cycle reads
    always_comb begin
        for (int r = 0; r < SRC_N + ISSUE_N; r++) begin
            rdata_o[r] = map_q[raddr_i[r]];
            // slot 1 checked last so it wins
            for (int k = 0; k < ISSUE_N; k++) begin
                if (we_i[k] && (waddr_i[k] == raddr_i[r])) begin
                    rdata_o[r] = wdata_i[k];
                end
            end
        end
    end

    // retire port gating must drop r0 writes
    for (genvar k = 0; k < ISSUE_N; k++) begin : g_chk
        a_no_r0_write: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            we_i[k] |-> (waddr_i[k] != '0)
        );
    end

endmodule

//--- hw/rename_pkg.sv
package rename_pkg;

    // architectural register space
    localparam int AREG_N = 32;
    localparam int AREG_W = 5;

    // reorder buffer
    localparam int ROB_DEPTH = 64;
    localparam int ROB_W     = 6;
    // one bundle may already be in flight when room is sampled
    localparam int ROB_LIMIT = 60;

    // bundle shape, slot k owns sources 2k and 2k+1
    localparam int ISSUE_N = 2;
    localparam int SRC_N   = 4;

    localparam int XLEN = 32;

    typedef logic [AREG_W-1:0] areg_id_t;
    typedef logic [ROB_W-1:0]  rob_id_t;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_MDU,
        OP_LSU,
        OP_BR
    } op_t;

    // one mapping entry
    typedef struct packed {
        logic    check;
        rob_id_t rob_id;
    } rat_entry_t;

    // decoded bundle from decode
    typedef struct packed {
        logic [XLEN-1:0]               pc;
        logic [ISSUE_N-1:0]            valid;
        logic [ISSUE_N-1:0]            w_reg;
        areg_id_t [ISSUE_N-1:0]        dst;
        areg_id_t [SRC_N-1:0]          src;
        logic [SRC_N-1:0]              src_need;
        op_t [ISSUE_N-1:0]             op;
        logic [ISSUE_N-1:0][XLEN-1:0]  imm;
    } dec_pkt_t;

    // renamed packet towards dispatch
    typedef struct packed {
        logic [XLEN-1:0]               pc;
        logic [ISSUE_N-1:0]            valid;
        areg_id_t [ISSUE_N-1:0]        dst;
        rob_id_t [ISSUE_N-1:0]         rob_id;
        logic [ISSUE_N-1:0]            check;
        rob_id_t [SRC_N-1:0]           src_rob_id;
        logic [SRC_N-1:0][XLEN-1:0]    src_data;
        logic [SRC_N-1:0]              data_valid;
        op_t [ISSUE_N-1:0]             op;
        logic [ISSUE_N-1:0][XLEN-1:0]  imm;
    } ren_pkt_t;

    // one retiring instruction
    typedef struct packed {
        logic            w_valid;
        areg_id_t        dst;
        rob_id_t         rob_id;
        logic            check;
        logic [XLEN-1:0] data;
    } retire_t;

endpackage

//--- hw/rename_stage.sv
`timescale 1ns/1ps

module rename_stage import rename_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  in_valid_i,
    input  dec_pkt_t              dec_i,
    output logic                  in_ready_o,
    output ren_pkt_t              ren_o,
    input  logic                  out_ready_i,
    input  retire_t [ISSUE_N-1:0] retire_i,
    input  logic                  rob_room_i,
    input  rob_id_t               alloc_id0_i,
    input  rob_id_t               alloc_id1_i,
    output logic [1:0]            issue_cnt_o
);

    logic [ISSUE_N-1:0]             issue;
    logic [ISSUE_N-1:0]             spec_we;
    rob_id_t [ISSUE_N-1:0]          alloc_id;
    rat_entry_t [ISSUE_N-1:0]       spec_new;
    rat_entry_t [SRC_N-1:0]         spec_rd;
    rat_entry_t [SRC_N-1:0]         cmt_src_rd;
    rat_entry_t [ISSUE_N-1:0]       cmt_dst_rd;
    logic [ISSUE_N-1:0]             ret_we;
    areg_id_t [ISSUE_N-1:0]         ret_addr;
    rat_entry_t [ISSUE_N-1:0]       ret_entry;
    logic [ISSUE_N-1:0][XLEN-1:0]   ret_data;
    logic [SRC_N-1:0][XLEN-1:0]     src_data;
    ren_pkt_t                       ren_d;
    ren_pkt_t                       ren_q;

    assign in_ready_o = rob_room_i && !flush_i && out_ready_i;
    assign alloc_id   = {alloc_id1_i, alloc_id0_i};

    always_comb begin
        for (int k = 0; k < ISSUE_N; k++) begin
            issue[k]   = in_valid_i && in_ready_o && dec_i.valid[k];
            spec_we[k] = issue[k] && dec_i.w_reg[k] && (dec_i.dst[k] != '0);
            // flip the committed check bit so the new mapping differs
            spec_new[k].check  = ~cmt_dst_rd[k].check;
            spec_new[k].rob_id = alloc_id[k];

            ret_we[k]             = retire_i[k].w_valid && (retire_i[k].dst != '0);
            ret_addr[k]           = retire_i[k].dst;
            ret_entry[k].check    = retire_i[k].check;
            ret_entry[k].rob_id   = retire_i[k].rob_id;
            ret_data[k]           = retire_i[k].data;
        end
    end

    assign issue_cnt_o = {1'b0, issue[0]} + {1'b0, issue[1]};

    spec_rat spec_rat_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .raddr_i (dec_i.src),
        .rdata_o (spec_rd),
        .waddr_i (dec_i.dst),
        .we_i    (spec_we),
        .wdata_i (spec_new)
    );

    // upper two read ports look up the destinations
    commit_rat commit_rat_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .raddr_i ({dec_i.dst, dec_i.src}),
        .rdata_o ({cmt_dst_rd, cmt_src_rd}),
        .waddr_i (ret_addr),
        .we_i    (ret_we),
        .wdata_i (ret_entry)
    );

    arch_regfile arch_regfile_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (dec_i.src),
        .rdata_o (src_data),
        .waddr_i (ret_addr),
        .we_i    (ret_we),
        .wdata_i (ret_data)
    );

    // no intra-bundle forwarding from slot 0 to slot 1
    always_comb begin
        ren_d.pc     = dec_i.pc;
        ren_d.valid  = issue;
        ren_d.dst    = dec_i.dst;
        ren_d.rob_id = alloc_id;
        for (int k = 0; k < ISSUE_N; k++) begin
            ren_d.check[k] = spec_new[k].check;
        end
        for (int i = 0; i < SRC_N; i++) begin
            ren_d.src_rob_id[i] = spec_rd[i].rob_id;
            // matching mappings mean the value is already committed
            ren_d.data_valid[i] = !dec_i.src_need[i] || (spec_rd[i] == cmt_src_rd[i]);
        end
        ren_d.src_data = src_data;
        ren_d.op       = dec_i.op;
        ren_d.imm      = dec_i.imm;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ren_q <= '0;
        end else if (out_ready_i) begin
            ren_q <= ren_d;
        end
    end

    assign ren_o = ren_q;

    // the two slots of a bundle get consecutive ROB ids
    a_alloc_ids_adjacent: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        alloc_id1_i == (alloc_id0_i + rob_id_t'(1))
    );

endmodule

//--- hw/rename_top.sv
`timescale 1ns/1ps

module rename_top import rename_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  in_valid_i,
    input  dec_pkt_t              dec_i,
    output logic                  in_ready_o,
    output ren_pkt_t              ren_o,
    input  logic                  out_ready_i,
    input  retire_t [ISSUE_N-1:0] retire_i
);

    logic       rob_room;
    rob_id_t    alloc_id0;
    rob_id_t    alloc_id1;
    logic [1:0] issue_cnt;

    rob_alloc rob_alloc_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .issue_cnt_i (issue_cnt),
        .retire_i    (retire_i),
        .rob_room_o  (rob_room),
        .alloc_id0_o (alloc_id0),
        .alloc_id1_o (alloc_id1)
    );

    rename_stage rename_stage_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .in_valid_i  (in_valid_i),
        .dec_i       (dec_i),
        .in_ready_o  (in_ready_o),
        .ren_o       (ren_o),
        .out_ready_i (out_ready_i),
        .retire_i    (retire_i),
        .rob_room_i  (rob_room),
        .alloc_id0_i (alloc_id0),
        .alloc_id1_i (alloc_id1),
        .issue_cnt_o (issue_cnt)
    );

endmodule

//--- hw/rob_alloc.sv
`timescale 1ns/1ps

module rob_alloc import rename_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic [1:0]            issue_cnt_i,
    input  retire_t [ISSUE_N-1:0] retire_i,
    output logic                  rob_room_o,
    output rob_id_t               alloc_id0_o,
    output rob_id_t               alloc_id1_o
);

    // one extra bit so a full ROB is representable
    logic [ROB_W:0] cnt_q;
    logic [ROB_W:0] cnt_d;
    logic [1:0]     ret_cnt;
    logic           room_q;
    rob_id_t        ptr0_q;
    rob_id_t        ptr1_q;

    assign ret_cnt = {1'b0, retire_i[0].w_valid} + {1'b0, retire_i[1].w_valid};
    assign cnt_d   = cnt_q + (ROB_W + 1)'(issue_cnt_i) - (ROB_W + 1)'(ret_cnt);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            cnt_q  <= '0;
            ptr0_q <= '0;
            ptr1_q <= rob_id_t'(1);
            room_q <= 1'b1;
        end else begin
            cnt_q  <= cnt_d;
            // ids wrap naturally at ROB_DEPTH
            ptr0_q <= ptr0_q + rob_id_t'(issue_cnt_i);
            ptr1_q <= ptr1_q + rob_id_t'(issue_cnt_i);
            // sampled from the old count, lags one cycle
            room_q <= (cnt_q <= (ROB_W + 1)'(ROB_LIMIT));
        end
    end

    assign rob_room_o  = room_q;
    assign alloc_id0_o = ptr0_q;
    assign alloc_id1_o = ptr1_q;

    // room flag plus headroom must keep the count in range
    a_cnt_range: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (cnt_q <= (ROB_W + 1)'(ROB_DEPTH)) &&
        ((cnt_q + (ROB_W + 1)'(issue_cnt_i)) >= (ROB_W + 1)'(ret_cnt))
    );

endmodule

//--- hw/spec_rat.sv
`timescale 1ns/1ps

module spec_rat import rename_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  areg_id_t [SRC_N-1:0]     raddr_i,
    output rat_entry_t [SRC_N-1:0]   rdata_o,
    input  areg_id_t [ISSUE_N-1:0]   waddr_i,
    input  logic [ISSUE_N-1:0]       we_i,
    input  rat_entry_t [ISSUE_N-1:0] wdata_i
);

    rat_entry_t [AREG_N-1:0] map_q;

    // later slot overwrites earlier one on a shared address
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            map_q <= '0;
        end else begin
            for (int k = 0; k < ISSUE_N; k++) begin
                if (we_i[k]) begin
                    map_q[waddr_i[k]] <= wdata_i[k];
                end
            end
        end
    end

    // no bypass, writes show after the edge
    always_comb begin
        for (int r = 0; r < SRC_N; r++) begin
            rdata_o[r] = map_q[raddr_i[r]];
        end
    end

    // r0 is never renamed, the issue logic must mask it
    for (genvar k = 0; k < ISSUE_N; k++) begin : g_chk
        a_no_r0_write: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            we_i[k] |-> (waddr_i[k] != '0)
        );
    end

endmodule

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f tb.f --top-module rename_tb -o rename_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/rename_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "simulation did not report success"
exit 1

//--- tb.f
hw/rename_pkg.sv
hw/spec_rat.sv
hw/commit_rat.sv
hw/arch_regfile.sv
hw/rob_alloc.sv
hw/rename_stage.sv
hw/rename_top.sv
verif/tb_clkgen.sv
verif/rename_tb.sv

//--- verif/rename_tb.sv
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

    // stimulus stays below this bound
    localparam int TEST_CYCLES    = 600;
    localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    dec_pkt_t              dec;
    logic                  in_ready;
    ren_pkt_t              ren;
    logic                  out_ready;
    retire_t [ISSUE_N-1:0] retire;
    logic                  flush;

    integer seed      = 32'h5e17;
    int     checks    = 0;
    int     errors    = 0;
    int     test_no   = 0;
    int     test_err0 = 0;
    int     cycles    = 0;

    // reference model of tables, ROB counter and output register
    rat_entry_t      m_spec [AREG_N];
    rat_entry_t      m_cmt [AREG_N];
    logic [XLEN-1:0] m_regs [AREG_N];
    int              m_cnt;
    rob_id_t         m_ptr0;
    logic            m_room;
    ren_pkt_t        m_ren;
    retire_t         pending [$];

    logic     chk_en = 1'b0;
    logic     exp_ready;
    ren_pkt_t exp_ren;

    tb_clkgen tb_clkgen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rename_top rename_top_i (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .flush_i     (flush),
        .in_valid_i  (in_valid),
        .dec_i       (dec),
        .in_ready_o  (in_ready),
        .ren_o       (ren),
        .out_ready_i (out_ready),
        .retire_i    (retire)
    );

    task automatic check_bit(string name, logic exp, logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s exp=%b got=%b", $time, name, exp, got);
        end
    endtask

    task automatic check_word(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic check_id(string name, rob_id_t exp, rob_id_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s exp=%0d got=%0d", $time, name, exp, got);
        end
    endtask

    task automatic check_entry(string name, rat_entry_t exp, rat_entry_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    // committed mapping as seen through the retire bypass
    function automatic rat_entry_t cmt_view(areg_id_t a);
        rat_entry_t e;
        e = m_cmt[a];
        for (int k = 0; k < ISSUE_N; k++) begin
            if (retire[k].w_valid && retire[k].dst != '0 && retire[k].dst == a) begin
                e.check  = retire[k].check;
                e.rob_id = retire[k].rob_id;
            end
        end
        return e;
    endfunction

    function automatic logic [XLEN-1:0] reg_view(areg_id_t a);
        logic [XLEN-1:0] v;
        v = m_regs[a];
        for (int k = 0; k < ISSUE_N; k++) begin
            if (retire[k].w_valid && retire[k].dst != '0 && retire[k].dst == a) begin
                v = retire[k].data;
            end
        end
        if (a == '0) begin
            v = '0;
        end
        return v;
    endfunction

    function automatic ren_pkt_t predict_ren(dec_pkt_t d, logic [1:0] iss);
        ren_pkt_t   p;
        rat_entry_t s;
        rat_entry_t c;
        p       = '0;
        p.pc    = d.pc;
        p.valid = iss;
        p.dst   = d.dst;
        p.op    = d.op;
        p.imm   = d.imm;
        for (int k = 0; k < ISSUE_N; k++) begin
            c           = cmt_view(d.dst[k]);
            p.rob_id[k] = m_ptr0 + rob_id_t'(k);
            p.check[k]  = ~c.check;
        end
        // no forwarding from slot 0 into slot 1 sources
        for (int i = 0; i < SRC_N; i++) begin
            s                 = m_spec[d.src[i]];
            c                 = cmt_view(d.src[i]);
            p.src_rob_id[i]   = s.rob_id;
            p.src_data[i]     = reg_view(d.src[i]);
            p.data_valid[i]   = !d.src_need[i] || (s == c);
        end
        return p;
    endfunction

    // advance the model over the coming edge once inputs are driven
    task automatic model_cycle();
        logic [1:0] iss;
        ren_pkt_t   nxt;
        retire_t    r;
        int         n_ret;
        exp_ready = m_room && !flush && out_ready;
        exp_ren   = m_ren;
        chk_en    = 1'b1;
        for (int k = 0; k < ISSUE_N; k++) begin
            iss[k] = in_valid && exp_ready && dec.valid[k];
        end
        nxt   = predict_ren(dec, iss);
        n_ret = 0;
        for (int k = 0; k < ISSUE_N; k++) begin
            if (iss[k]) begin
                r.w_valid = 1'b1;
                r.dst     = (dec.w_reg[k] && dec.dst[k] != '0) ? dec.dst[k] : '0;
                r.rob_id  = nxt.rob_id[k];
                r.check   = nxt.check[k];
                r.data    = $random(seed);
                pending.push_back(r);
                if (r.dst != '0) begin
                    m_spec[r.dst].check  = r.check;
                    m_spec[r.dst].rob_id = r.rob_id;
                end
            end
        end
        for (int k = 0; k < ISSUE_N; k++) begin
            if (retire[k].w_valid) begin
                n_ret++;
                if (retire[k].dst != '0) begin
                    m_cmt[retire[k].dst].check  = retire[k].check;
                    m_cmt[retire[k].dst].rob_id = retire[k].rob_id;
                    m_regs[retire[k].dst]       = retire[k].data;
                end
            end
        end
        // room comes from the count before this edge
        m_room = (m_cnt <= ROB_LIMIT);
        m_cnt  = m_cnt + int'(iss[0]) + int'(iss[1]) - n_ret;
        m_ptr0 = m_ptr0 + rob_id_t'(int'(iss[0]) + int'(iss[1]));
        if (out_ready) begin
            m_ren = nxt;
        end
        if (flush) begin
            for (int a = 0; a < AREG_N; a++) begin
                m_spec[a] = '0;
                m_cmt[a]  = '0;
            end
            m_cnt  = 0;
            m_ptr0 = '0;
            m_room = 1'b1;
            m_ren  = '0;
            pending.delete();
        end
    endtask

    task automatic tick();
        model_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic set_retire(int n);
        retire = '0;
        for (int k = 0; k < n && k < ISSUE_N; k++) begin
            if (pending.size() > 0) begin
                retire[k] = pending.pop_front();
            end
        end
    endtask

    task automatic drain();
        in_valid = 1'b0;
        while (pending.size() > 0) begin
            set_retire(2);
            tick();
        end
        retire = '0;
    endtask

    function automatic dec_pkt_t rand_bundle(logic [1:0] slots, logic wr);
        dec_pkt_t d;
        d.pc       = $random(seed);
        d.valid    = slots;
        d.w_reg    = {wr, wr};
        d.src_need = 4'($random(seed));
        for (int k = 0; k < ISSUE_N; k++) begin
            d.dst[k] = areg_id_t'($random(seed));
            d.op[k]  = op_t'(2'($random(seed)));
            d.imm[k] = $random(seed);
        end
        for (int i = 0; i < SRC_N; i++) begin
            d.src[i] = areg_id_t'($random(seed));
        end
        return d;
    endfunction

    task automatic end_test(string name);
        test_no++;
        $display("test %0d %s: %0d errors", test_no, name, errors - test_err0);
        test_err0 = errors;
    endtask

    task automatic compare_outputs();
        rat_entry_t ee;
        rat_entry_t ge;
        check_bit("in_ready_o", exp_ready, in_ready);
        check_word("ren_o.pc", exp_ren.pc, ren.pc);
        for (int k = 0; k < ISSUE_N; k++) begin
            ee.check  = exp_ren.check[k];
            ee.rob_id = exp_ren.rob_id[k];
            ge.check  = ren.check[k];
            ge.rob_id = ren.rob_id[k];
            check_bit($sformatf("ren_o.valid[%0d]", k), exp_ren.valid[k], ren.valid[k]);
            check_entry($sformatf("ren_o.dst_entry[%0d]", k), ee, ge);
            check_word($sformatf("ren_o.dst[%0d]", k), 32'(exp_ren.dst[k]), 32'(ren.dst[k]));
            check_word($sformatf("ren_o.op[%0d]", k), 32'(exp_ren.op[k]), 32'(ren.op[k]));
            check_word($sformatf("ren_o.imm[%0d]", k), exp_ren.imm[k], ren.imm[k]);
        end
        for (int i = 0; i < SRC_N; i++) begin
            check_id($sformatf("ren_o.src_rob_id[%0d]", i), exp_ren.src_rob_id[i],
                     ren.src_rob_id[i]);
            check_word($sformatf("ren_o.src_data[%0d]", i), exp_ren.src_data[i],
                       ren.src_data[i]);
            check_bit($sformatf("ren_o.data_valid[%0d]", i), exp_ren.data_valid[i],
                      ren.data_valid[i]);
        end
    endtask

    // outputs settle long before the falling edge
    always @(negedge clk) begin
        if (chk_en) begin
            compare_outputs();
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        dec_pkt_t        d;
        rob_id_t         wr_id;
        logic            wr_chk;
        logic [XLEN-1:0] wr_data;
        ren_pkt_t        held;
        logic [1:0]      slots;
        rat_entry_t      ee;
        rat_entry_t      ge;
        for (int a = 0; a < AREG_N; a++) begin
            m_spec[a] = '0;
            m_cmt[a]  = '0;
            m_regs[a] = '0;
        end
        m_cnt     = 0;
        m_ptr0    = '0;
        m_room    = 1'b1;
        m_ren     = '0;
        in_valid  = 1'b0;
        dec       = '0;
        out_ready = 1'b1;
        flush     = 1'b0;
        retire    = '0;
        wait (rst_n === 1'b1);
        tick();

        check_bit("in_ready_o after reset", 1'b1, in_ready);
        for (int k = 0; k < ISSUE_N; k++) begin
            check_bit($sformatf("ren_o.valid[%0d] after reset", k), 1'b0, ren.valid[k]);
        end
        d          = rand_bundle(2'b11, 1'b0);
        d.src_need = 4'hf;
        dec        = d;
        in_valid   = 1'b1;
        tick();
        for (int i = 0; i < SRC_N; i++) begin
            check_id($sformatf("src_rob_id[%0d] after reset", i), '0, ren.src_rob_id[i]);
            check_bit($sformatf("data_valid[%0d] after reset", i), 1'b1, ren.data_valid[i]);
            check_word($sformatf("src_data[%0d] after reset", i), '0, ren.src_data[i]);
        end
        end_test("reset state");

        repeat (60) begin
            slots = 2'($random(seed));
            if (slots == 2'b00) begin
                slots = 2'b11;
            end
            dec      = rand_bundle(slots, 1'($random(seed)));
            in_valid = 1'b1;
            set_retire(2);
            tick();
        end
        drain();
        end_test("allocation");

        d        = rand_bundle(2'b01, 1'b1);
        d.dst[0] = 5'd7;
        dec      = d;
        in_valid = 1'b1;
        wr_id    = m_ptr0;
        wr_chk   = ~m_cmt[7].check;
        tick();
        ee.check  = wr_chk;
        ee.rob_id = wr_id;
        ge.check  = ren.check[0];
        ge.rob_id = ren.rob_id[0];
        check_entry("writer entry of r7", ee, ge);
        d             = rand_bundle(2'b01, 1'b0);
        d.src[0]      = 5'd7;
        d.src_need[0] = 1'b1;
        dec           = d;
        tick();
        check_id("src_rob_id[0] reading r7", wr_id, ren.src_rob_id[0]);
        check_bit("data_valid[0] reading r7", 1'b0, ren.data_valid[0]);
        end_test("dependency");

        // retire the oldest writer while r7 is read again
        wr_data = pending[0].data;
        set_retire(1);
        tick();
        check_bit("data_valid[0] with same-cycle retire", 1'b1, ren.data_valid[0]);
        check_word("src_data[0] with same-cycle retire", wr_data, ren.src_data[0]);
        retire = '0;
        tick();
        check_bit("data_valid[0] after retire", 1'b1, ren.data_valid[0]);
        check_word("src_data[0] after retire", wr_data, ren.src_data[0]);
        drain();
        end_test("retire");

        dec      = rand_bundle(2'b11, 1'b0);
        in_valid = 1'b1;
        tick();
        held      = m_ren;
        out_ready = 1'b0;
        repeat (3) begin
            dec = rand_bundle(2'b11, 1'b0);
            tick();
        end
        check_word("ren_o.pc under back-pressure", held.pc, ren.pc);
        check_word("ren_o.imm[0] under back-pressure", held.imm[0], ren.imm[0]);
        check_bit("in_ready_o under back-pressure", 1'b0, in_ready);
        out_ready = 1'b1;
        drain();
        in_valid = 1'b1;
        repeat (40) begin
            dec = rand_bundle(2'b11, 1'b0);
            tick();
        end
        check_bit("in_ready_o at capacity", 1'b0, in_ready);
        end_test("back-pressure and capacity");

        in_valid = 1'b0;
        flush    = 1'b1;
        tick();
        flush         = 1'b0;
        d             = rand_bundle(2'b01, 1'b0);
        d.src[0]      = 5'd7;
        d.src_need[0] = 1'b1;
        dec           = d;
        in_valid      = 1'b1;
        tick();
        check_bit("ren_o.valid[0] after flush", 1'b1, ren.valid[0]);
        check_id("src_rob_id[0] after flush", '0, ren.src_rob_id[0]);
        check_bit("data_valid[0] after flush", 1'b1, ren.data_valid[0]);
        check_word("src_data[0] after flush", wr_data, ren.src_data[0]);
        in_valid = 1'b0;
        tick();
        end_test("flush");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int PERIOD_NS    = 20;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release just after an edge, like the other stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_n_o = 1'b1;
    end

endmodule
